// ==== tb.f ====
design/aud_pkg.sv
design/aud_ctrl.sv
design/aud_recorder.sv
design/aud_dsp.sv
design/aud_sram_port.sv
design/aud_recorder_top.sv
bench/sram_model.sv
bench/aud_props.sv
bench/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_top -f tb.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
	exit 0
fi
exit 1

// ==== bench/tb_top.sv ====
`default_nettype none

module tb_top;

	import aud_pkg::*;

	localparam int ADDR_W   = 6;
	localparam int TPS      = 8;
	localparam int WAIT_MAX = 16;
	localparam int KEY_REC  = 0;
	localparam int KEY_PLAY = 1;
	localparam int KEY_STOP = 2;

	logic                clk;
	logic                rst_n;
	logic                key_rec;
	logic                key_play;
	logic                key_stop;
	play_cfg_t           play_cfg;
	logic                sample_tick;
	logic [SAMPLE_W-1:0] adc_sample;
	logic [SAMPLE_W-1:0] sram_rdata;
	logic [ADDR_W-1:0]   sram_addr;
	logic [SAMPLE_W-1:0] sram_wdata;
	logic                sram_we_n;
	logic [SAMPLE_W-1:0] dac_sample;
	logic                dac_valid;
	aud_mode_e           mode;
	logic [5:0]          record_time;
	logic [5:0]          play_time;

	integer              seed;
	int                  err_cnt;
	// samples that were actually written, in address order
	logic [SAMPLE_W-1:0] rec[$];
	logic [SAMPLE_W-1:0] expq[$];

	aud_recorder_top #(
		.ADDR_W        (ADDR_W),
		.TICKS_PER_SEC (TPS)
	) uut (
		.i_clk         (clk),
		.i_rst_n       (rst_n),
		.i_key_rec     (key_rec),
		.i_key_play    (key_play),
		.i_key_stop    (key_stop),
		.i_play_cfg    (play_cfg),
		.i_sample_tick (sample_tick),
		.i_adc_sample  (adc_sample),
		.i_sram_rdata  (sram_rdata),
		.o_sram_addr   (sram_addr),
		.o_sram_wdata  (sram_wdata),
		.o_sram_we_n   (sram_we_n),
		.o_dac_sample  (dac_sample),
		.o_dac_valid   (dac_valid),
		.o_mode        (mode),
		.o_record_time (record_time),
		.o_play_time   (play_time)
	);

	sram_model #(
		.ADDR_W (ADDR_W),
		.DATA_W (SAMPLE_W)
	) u_sram (
		.i_clk   (clk),
		.i_we_n  (sram_we_n),
		.i_addr  (sram_addr),
		.i_wdata (sram_wdata),
		.o_rdata (sram_rdata)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			err_cnt++;
			abort_run($sformatf("CHECK FAILED at %0t: %s got %0h expected %0h",
				$time, name, got, exp));
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	function automatic logic [SAMPLE_W-1:0] draw_sample();
		logic [31:0] r;
		r = $random(seed);
		return r[SAMPLE_W-1:0];
	endfunction

	// s[j-1] + (s[j]-s[j-1])*k/f, signed, truncated toward zero
	function automatic logic [SAMPLE_W-1:0] lerp_value(input logic [SAMPLE_W-1:0] a,
		input logic [SAMPLE_W-1:0] b, input int k, input int f);
		int          sa;
		int          sb;
		int          q;
		logic [31:0] sum;
		sa  = int'($signed(a));
		sb  = int'($signed(b));
		q   = ((sb - sa) * k) / f;
		sum = sa + q;
		return sum[SAMPLE_W-1:0];
	endfunction

	task automatic wait_mode(input aud_mode_e want, input string what);
		int t;
		t = 0;
		while (mode !== want && t < WAIT_MAX) begin
			@(negedge clk);
			t++;
		end
		if (mode !== want)
			abort_run($sformatf("timeout: mode never reached %s (%s)", want.name(), what));
	endtask

	task automatic press_key(input int which, input aud_mode_e want);
		case (which)
			KEY_REC:  key_rec = 1'b1;
			KEY_PLAY: key_play = 1'b1;
			default:  key_stop = 1'b1;
		endcase
		@(negedge clk);
		wait_mode(want, "after key press");
		key_rec  = 1'b0;
		key_play = 1'b0;
		key_stop = 1'b0;
		// let the key registers see the release
		idle(2);
	endtask

	task automatic send_tick(input logic [SAMPLE_W-1:0] smp);
		sample_tick = 1'b1;
		adc_sample  = smp;
		@(negedge clk);
		sample_tick = 1'b0;
	endtask

	task automatic record_tick(input logic keep);
		logic [SAMPLE_W-1:0] smp;
		smp         = draw_sample();
		sample_tick = 1'b1;
		adc_sample  = smp;
		// mid low phase, the write lands at the next rising edge
		#2;
		if (keep) begin
			check("o_sram_we_n", 32'(sram_we_n), 32'd0);
			check("o_sram_addr", 32'(sram_addr), 32'(rec.size()));
			check("o_sram_wdata", 32'(sram_wdata), 32'(smp));
			rec.push_back(smp);
		end else begin
			check("o_sram_we_n", 32'(sram_we_n), 32'd1);
		end
		@(negedge clk);
		sample_tick = 1'b0;
		idle(3);
	endtask

	// one frame, expected output two clocks later
	task automatic play_tick(input logic [SAMPLE_W-1:0] exp);
		int t;
		t = 0;
		send_tick('0);
		while (!dac_valid && t < WAIT_MAX) begin
			@(negedge clk);
			t++;
		end
		if (!dac_valid)
			abort_run("timeout: no o_dac_valid after a playback tick");
		check("o_dac_sample", 32'(dac_sample), 32'(exp));
		idle(2);
	endtask

	task automatic quiet_tick(input logic [SAMPLE_W-1:0] held);
		send_tick('0);
		repeat (3) begin
			@(negedge clk);
			check("o_dac_valid", 32'(dac_valid), 32'd0);
			check("o_dac_sample", 32'(dac_sample), 32'(held));
		end
	endtask

	task automatic build_expected(input spd_kind_e kind, input int f);
		int                  n;
		int                  j;
		int                  k;
		logic [SAMPLE_W-1:0] prev;
		n = rec.size();
		expq.delete();
		case (kind)
			SPD_FAST: begin
				j = 0;
				while (j < n) begin
					expq.push_back(rec[j]);
					j += f;
				end
			end
			SPD_SLOW_HOLD: begin
				for (j = 0; j < n; j++)
					for (k = 0; k < f; k++)
						expq.push_back(rec[j]);
			end
			SPD_SLOW_LERP: begin
				for (j = 0; j < n; j++) begin
					prev = (j == 0) ? '0 : rec[j-1];
					for (k = 0; k < f; k++)
						expq.push_back(lerp_value(prev, rec[j], k, f));
				end
			end
			default: begin
				for (j = 0; j < n; j++)
					expq.push_back(rec[j]);
			end
		endcase
	endtask

	task automatic play_and_check(input spd_kind_e kind, input logic [3:0] f);
		int i;
		build_expected(kind, int'(f));
		play_cfg = '{kind: kind, factor: f};
		press_key(KEY_PLAY, MODE_PLAY);
		for (i = 0; i < expq.size(); i++) begin
			play_tick(expq[i]);
			if (i < expq.size() - 1)
				check("o_mode", 32'(mode), 32'(MODE_PLAY));
		end
		wait_mode(MODE_STOP, "playback done");
	endtask

	task automatic test_reset_and_normal();
		check("o_mode", 32'(mode), 32'(MODE_STOP));
		check("o_record_time", 32'(record_time), 32'd0);
		check("o_play_time", 32'(play_time), 32'd0);
		check("o_sram_we_n", 32'(sram_we_n), 32'd1);
		check("o_dac_valid", 32'(dac_valid), 32'd0);
		rec.delete();
		press_key(KEY_REC, MODE_RECD);
		repeat (20) record_tick(1'b1);
		press_key(KEY_STOP, MODE_STOP);
		check("o_record_time", 32'(record_time), 32'd2);
		play_and_check(SPD_NORMAL, 4'd1);
		check("o_play_time", 32'(play_time), 32'd2);
	endtask

	task automatic test_pause();
		int i;
		rec.delete();
		press_key(KEY_REC, MODE_RECD);
		repeat (6) record_tick(1'b1);
		press_key(KEY_REC, MODE_RECD_PAUSE);
		// dropped while paused
		repeat (3) record_tick(1'b0);
		press_key(KEY_REC, MODE_RECD);
		repeat (6) record_tick(1'b1);
		press_key(KEY_STOP, MODE_STOP);
		check("o_record_time", 32'(record_time), 32'd1);
		play_cfg = '{kind: SPD_NORMAL, factor: 4'd1};
		press_key(KEY_PLAY, MODE_PLAY);
		for (i = 0; i < 5; i++)
			play_tick(rec[i]);
		press_key(KEY_PLAY, MODE_PLAY_PAUSE);
		repeat (3) quiet_tick(rec[4]);
		press_key(KEY_PLAY, MODE_PLAY);
		for (i = 5; i < 8; i++)
			play_tick(rec[i]);
		press_key(KEY_STOP, MODE_STOP);
		quiet_tick(rec[7]);
	endtask

	task automatic test_full_memory();
		rec.delete();
		press_key(KEY_REC, MODE_RECD);
		repeat (63) record_tick(1'b1);
		check("o_mode", 32'(mode), 32'(MODE_RECD));
		record_tick(1'b1);
		wait_mode(MODE_STOP, "memory full");
		check("o_record_time", 32'(record_time), 32'd8);
		play_and_check(SPD_NORMAL, 4'd1);
	endtask

	initial begin
		seed        = 32'h136e5e4e;
		err_cnt     = 0;
		rst_n       = 1'b0;
		key_rec     = 1'b0;
		key_play    = 1'b0;
		key_stop    = 1'b0;
		play_cfg    = '{kind: SPD_NORMAL, factor: 4'd1};
		sample_tick = 1'b0;
		adc_sample  = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		idle(1);

		test_reset_and_normal();
		// 20 samples: indices 0, 3, ... 18
		play_and_check(SPD_FAST, 4'd3);
		play_and_check(SPD_SLOW_HOLD, 4'd2);
		play_and_check(SPD_SLOW_LERP, 4'd4);
		test_pause();
		test_full_memory();

		if (err_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/aud_props.sv ====
`default_nettype none

module aud_props (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  aud_pkg::aud_mode_e i_mode,
	input  logic               i_sram_we_n,
	input  logic               i_dac_valid,
	input  logic               i_sample_tick
);

	import aud_pkg::*;

	// memory is written only while recording
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_sram_we_n |-> i_mode == MODE_RECD)
		else $error("sram write outside RECD, mode %0d", i_mode);

	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_dac_valid |-> i_mode == MODE_PLAY)
		else $error("dac valid outside PLAY, mode %0d", i_mode);

	// address cycle plus registered read
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_dac_valid |-> $past(i_sample_tick, 2) && !$past(i_sample_tick, 1))
		else $error("dac valid not two clocks after a tick");

endmodule

bind aud_recorder_top aud_props u_props (
	.i_clk         (i_clk),
	.i_rst_n       (i_rst_n),
	.i_mode        (o_mode),
	.i_sram_we_n   (o_sram_we_n),
	.i_dac_valid   (o_dac_valid),
	.i_sample_tick (i_sample_tick)
);

`default_nettype wire

// ==== bench/sram_model.sv ====
`default_nettype none

module sram_model #(
	parameter int ADDR_W = 6,
	parameter int DATA_W = 16
) (
	input  logic              i_clk,
	input  logic              i_we_n,
	input  logic [ADDR_W-1:0] i_addr,
	input  logic [DATA_W-1:0] i_wdata,
	output logic [DATA_W-1:0] o_rdata
);

	logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];

	// write lands at the clock edge while we_n is low
	always_ff @(posedge i_clk) begin
		if (!i_we_n)
			mem[i_addr] <= i_wdata;
	end

	// asynchronous read
	assign o_rdata = mem[i_addr];

endmodule

`default_nettype wire

// ==== design/aud_recorder_top.sv ====
`default_nettype none

module aud_recorder_top #(
	parameter int ADDR_W        = 20,
	parameter int TICKS_PER_SEC = 32000
) (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  logic                          i_key_rec,
	input  logic                          i_key_play,
	input  logic                          i_key_stop,
	input  aud_pkg::play_cfg_t            i_play_cfg,
	input  logic                          i_sample_tick,
	input  logic [aud_pkg::SAMPLE_W-1:0]  i_adc_sample,
	input  logic [aud_pkg::SAMPLE_W-1:0]  i_sram_rdata,
	output logic [ADDR_W-1:0]             o_sram_addr,
	output logic [aud_pkg::SAMPLE_W-1:0]  o_sram_wdata,
	output logic                          o_sram_we_n,
	output logic [aud_pkg::SAMPLE_W-1:0]  o_dac_sample,
	output logic                          o_dac_valid,
	output aud_pkg::aud_mode_e            o_mode,
	output logic [5:0]                    o_record_time,
	output logic [5:0]                    o_play_time
);

	import aud_pkg::*;

	aud_mode_e           mode;
	play_cfg_t           play_cfg;
	sram_req_t           rec_req;
	logic [ADDR_W:0]     rec_len;
	logic                rec_done;
	logic                play_done;
	logic                rd_en;
	logic [ADDR_W-1:0]   rd_addr;
	logic [SAMPLE_W-1:0] rd_data;

	aud_ctrl #(
		.TICKS_PER_SEC(TICKS_PER_SEC)
	) u_ctrl (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_key_rec     (i_key_rec),
		.i_key_play    (i_key_play),
		.i_key_stop    (i_key_stop),
		.i_play_cfg    (i_play_cfg),
		.i_sample_tick (i_sample_tick),
		.i_rec_done    (rec_done),
		.i_play_done   (play_done),
		.o_mode        (mode),
		.o_play_cfg    (play_cfg),
		.o_record_time (o_record_time),
		.o_play_time   (o_play_time)
	);

	aud_recorder #(
		.ADDR_W(ADDR_W)
	) u_recorder (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_mode        (mode),
		.i_sample_tick (i_sample_tick),
		.i_adc_sample  (i_adc_sample),
		.o_req         (rec_req),
		.o_rec_len     (rec_len),
		.o_done        (rec_done)
	);

	aud_dsp #(
		.ADDR_W(ADDR_W)
	) u_dsp (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_mode        (mode),
		.i_play_cfg    (play_cfg),
		.i_sample_tick (i_sample_tick),
		.i_rec_len     (rec_len),
		.o_rd_en       (rd_en),
		.o_rd_addr     (rd_addr),
		.i_rd_data     (rd_data),
		.o_dac_sample  (o_dac_sample),
		.o_dac_valid   (o_dac_valid),
		.o_done        (play_done)
	);

	aud_sram_port #(
		.ADDR_W(ADDR_W)
	) u_sram_port (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_req         (rec_req),
		.i_rd_en       (rd_en),
		.i_rd_addr     (rd_addr),
		.o_rd_data     (rd_data),
		.o_sram_addr   (o_sram_addr),
		.o_sram_wdata  (o_sram_wdata),
		.o_sram_we_n   (o_sram_we_n),
		.i_sram_rdata  (i_sram_rdata)
	);

	assign o_mode = mode;

endmodule

`default_nettype wire

// ==== design/aud_sram_port.sv ====
`default_nettype none

module aud_sram_port #(
	parameter int ADDR_W = 20
) (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  aud_pkg::sram_req_t            i_req,
	input  logic                          i_rd_en,
	input  logic [ADDR_W-1:0]             i_rd_addr,
	output logic [aud_pkg::SAMPLE_W-1:0]  o_rd_data,
	output logic [ADDR_W-1:0]             o_sram_addr,
	output logic [aud_pkg::SAMPLE_W-1:0]  o_sram_wdata,
	output logic                          o_sram_we_n,
	input  logic [aud_pkg::SAMPLE_W-1:0]  i_sram_rdata
);

	logic [aud_pkg::SAMPLE_W-1:0] rd_q;

	// writer owns the bus only in its tick cycle
	assign o_sram_addr  = i_req.wr ? i_req.addr[ADDR_W-1:0] : i_rd_addr;
	assign o_sram_wdata = i_req.wdata;
	assign o_sram_we_n  = ~i_req.wr;

	// async read settles within the strobe cycle
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			rd_q <= '0;
		else if (i_rd_en)
			rd_q <= i_sram_rdata;
	end

	assign o_rd_data = rd_q;

endmodule

`default_nettype wire

// ==== design/aud_dsp.sv ====
`default_nettype none

module aud_dsp #(
	parameter int ADDR_W = 20
) (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  aud_pkg::aud_mode_e            i_mode,
	input  aud_pkg::play_cfg_t            i_play_cfg,
	input  logic                          i_sample_tick,
	input  logic [ADDR_W:0]               i_rec_len,
	output logic                          o_rd_en,
	output logic [ADDR_W-1:0]             o_rd_addr,
	input  logic [aud_pkg::SAMPLE_W-1:0]  i_rd_data,
	output logic [aud_pkg::SAMPLE_W-1:0]  o_dac_sample,
	output logic                          o_dac_valid,
	output logic                          o_done
);

	import aud_pkg::*;

	localparam int JW = ADDR_W + 1;

	aud_mode_e                  prev_mode;
	logic                       start;
	logic                       tick_play;
	logic [3:0]                 fact;
	logic [JW-1:0]              j_r;
	logic [JW-1:0]              cur_j;
	logic [JW-1:0]              step;
	logic [JW-1:0]              j_next;
	logic [3:0]                 phase_r;
	logic [3:0]                 cur_phase;
	logic [3:0]                 phase_next;
	logic                       adv;
	logic                       last;
	// stage 1 has the address on the bus, stage 2 has the read data
	logic                       s1_vld;
	logic                       s1_adv;
	logic                       s1_last;
	logic [3:0]                 s1_phase;
	logic                       s2_vld;
	logic                       s2_adv;
	logic                       s2_last;
	logic [3:0]                 s2_phase;
	logic [ADDR_W-1:0]          rd_addr_r;
	logic [SAMPLE_W-1:0]        prev_smp;
	logic signed [SAMPLE_W:0]   diff;
	logic signed [SAMPLE_W+4:0] prod;
	logic signed [SAMPLE_W+4:0] quot;
	logic signed [SAMPLE_W+4:0] lerp_sum;

	assign start     = (i_mode == MODE_PLAY) && (prev_mode == MODE_STOP);
	assign tick_play = (i_mode == MODE_PLAY) && i_sample_tick;
	assign fact      = (i_play_cfg.factor == 4'd0) ? 4'd1 : i_play_cfg.factor;
	assign cur_j     = start ? '0 : j_r;
	assign cur_phase = start ? '0 : phase_r;

	// per-frame stepping of the source index
	always_comb begin
		step       = JW'(1);
		adv        = 1'b1;
		phase_next = '0;
		case (i_play_cfg.kind)
			SPD_FAST: step = JW'(fact);
			SPD_SLOW_HOLD, SPD_SLOW_LERP: begin
				adv        = (cur_phase == fact - 4'd1);
				step       = adv ? JW'(1) : '0;
				phase_next = adv ? 4'd0 : cur_phase + 4'd1;
			end
			default: step = JW'(1);
		endcase
		j_next = cur_j + step;
		last   = adv && (j_next >= i_rec_len);
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			prev_mode <= MODE_STOP;
			j_r       <= '0;
			phase_r   <= '0;
			rd_addr_r <= '0;
			s1_vld    <= 1'b0;
			s1_adv    <= 1'b0;
			s1_last   <= 1'b0;
			s1_phase  <= '0;
			s2_vld    <= 1'b0;
			s2_adv    <= 1'b0;
			s2_last   <= 1'b0;
			s2_phase  <= '0;
		end else begin
			prev_mode <= i_mode;
			s1_vld    <= tick_play;
			s2_vld    <= s1_vld;
			s2_adv    <= s1_adv;
			s2_last   <= s1_last;
			s2_phase  <= s1_phase;
			if (tick_play) begin
				j_r       <= j_next;
				phase_r   <= phase_next;
				rd_addr_r <= cur_j[ADDR_W-1:0];
				s1_adv    <= adv;
				s1_last   <= last;
				s1_phase  <= cur_phase;
			end else if (start) begin
				j_r     <= '0;
				phase_r <= '0;
			end
		end
	end

	// s[j-1], zero before the first sample
	always_ff @(posedge i_clk) begin
		if (start)
			prev_smp <= '0;
		else if (s2_vld && s2_adv)
			prev_smp <= i_rd_data;
	end

	// signed division truncates toward zero
	assign diff = $signed({i_rd_data[SAMPLE_W-1], i_rd_data})
		- $signed({prev_smp[SAMPLE_W-1], prev_smp});
	assign prod     = diff * $signed({1'b0, s2_phase});
	assign quot     = prod / $signed({1'b0, fact});
	assign lerp_sum = $signed(prev_smp) + quot;

	assign o_dac_sample = (i_play_cfg.kind == SPD_SLOW_LERP) ?
		lerp_sum[SAMPLE_W-1:0] : i_rd_data;
	// a frame caught by a pause is not shown, but its done still counts
	assign o_dac_valid  = s2_vld && (i_mode == MODE_PLAY);
	assign o_done       = s2_vld && s2_last;
	assign o_rd_en      = s1_vld;
	assign o_rd_addr    = rd_addr_r;

endmodule

`default_nettype wire

// ==== design/aud_recorder.sv ====
`default_nettype none

module aud_recorder #(
	parameter int ADDR_W = 20
) (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  aud_pkg::aud_mode_e            i_mode,
	input  logic                          i_sample_tick,
	input  logic [aud_pkg::SAMPLE_W-1:0]  i_adc_sample,
	output aud_pkg::sram_req_t            o_req,
	output logic [ADDR_W:0]               o_rec_len,
	output logic                          o_done
);

	import aud_pkg::*;

	localparam logic [ADDR_W:0] LAST = {1'b0, {ADDR_W{1'b1}}};

	aud_mode_e       prev_mode;
	logic [ADDR_W:0] len_r;
	logic [ADDR_W:0] cur_len;
	logic            start;
	logic            wr;

	// a fresh take starts at address zero, even on its first cycle
	assign start   = (i_mode == MODE_RECD) && (prev_mode == MODE_STOP);
	assign cur_len = start ? '0 : len_r;
	assign wr      = (i_mode == MODE_RECD) && i_sample_tick;

	always_comb begin
		o_req                   = '0;
		o_req.wr                = wr;
		o_req.addr[ADDR_W-1:0]  = cur_len[ADDR_W-1:0];
		o_req.wdata             = i_adc_sample;
	end

	// write into the top address ends the take
	assign o_done = wr && (cur_len == LAST);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			prev_mode <= MODE_STOP;
			len_r     <= '0;
		end else begin
			prev_mode <= i_mode;
			if (start || wr)
				len_r <= cur_len + {{ADDR_W{1'b0}}, wr};
		end
	end

	assign o_rec_len = len_r;

endmodule

`default_nettype wire

// ==== design/aud_ctrl.sv ====
`default_nettype none

module aud_ctrl #(
	parameter int TICKS_PER_SEC = 32000
) (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_key_rec,
	input  logic                i_key_play,
	input  logic                i_key_stop,
	input  aud_pkg::play_cfg_t  i_play_cfg,
	input  logic                i_sample_tick,
	input  logic                i_rec_done,
	input  logic                i_play_done,
	output aud_pkg::aud_mode_e  o_mode,
	output aud_pkg::play_cfg_t  o_play_cfg,
	output logic [5:0]          o_record_time,
	output logic [5:0]          o_play_time
);

	import aud_pkg::*;

	localparam int TW = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
	localparam logic [TW-1:0] TICK_LAST = TW'(TICKS_PER_SEC - 1);

	logic [2:0]    key_q;
	logic [2:0]    key_qq;
	logic [2:0]    key_rise;
	logic          rec_edge;
	logic          play_edge;
	logic          stop_edge;
	aud_mode_e     mode_r;
	aud_mode_e     mode_nx;
	play_cfg_t     cfg_r;
	logic          rec_start;
	logic          play_start;
	// seconds in the upper six bits, frames within the second below
	logic [TW+5:0] rec_cnt;
	logic [TW+5:0] play_cnt;

	function automatic logic [TW+5:0] time_step(input logic [TW+5:0] cnt);
		logic [TW+5:0] nxt;
		nxt = cnt;
		if (cnt[TW-1:0] == TICK_LAST) begin
			nxt[TW-1:0]    = '0;
			nxt[TW+5:TW]   = cnt[TW+5:TW] + 6'd1;
		end else begin
			nxt[TW-1:0]    = cnt[TW-1:0] + 1'b1;
		end
		return nxt;
	endfunction

	// edge seen one cycle after the key is first sampled high
	assign key_rise  = key_q & ~key_qq;
	assign rec_edge  = key_rise[0];
	assign play_edge = key_rise[1];
	assign stop_edge = key_rise[2];

	always_comb begin
		mode_nx = mode_r;
		case (mode_r)
			MODE_STOP: begin
				if (rec_edge)
					mode_nx = MODE_RECD;
				else if (play_edge)
					mode_nx = MODE_PLAY;
			end
			MODE_RECD: begin
				if (i_rec_done || stop_edge)
					mode_nx = MODE_STOP;
				else if (rec_edge)
					mode_nx = MODE_RECD_PAUSE;
			end
			MODE_RECD_PAUSE: begin
				if (i_rec_done || stop_edge)
					mode_nx = MODE_STOP;
				else if (rec_edge)
					mode_nx = MODE_RECD;
			end
			MODE_PLAY: begin
				if (i_play_done || stop_edge)
					mode_nx = MODE_STOP;
				else if (play_edge)
					mode_nx = MODE_PLAY_PAUSE;
			end
			MODE_PLAY_PAUSE: begin
				// last frame may still land while paused
				if (i_play_done || stop_edge)
					mode_nx = MODE_STOP;
				else if (play_edge)
					mode_nx = MODE_PLAY;
			end
			default: mode_nx = MODE_STOP;
		endcase
	end

	assign rec_start  = (mode_r == MODE_STOP) && (mode_nx == MODE_RECD);
	assign play_start = (mode_r == MODE_STOP) && (mode_nx == MODE_PLAY);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			key_q    <= '0;
			key_qq   <= '0;
			mode_r   <= MODE_STOP;
			cfg_r    <= '{kind: SPD_NORMAL, factor: 4'd1};
			rec_cnt  <= '0;
			play_cnt <= '0;
		end else begin
			key_q  <= {i_key_stop, i_key_play, i_key_rec};
			key_qq <= key_q;
			mode_r <= mode_nx;
			if (play_start)
				cfg_r <= i_play_cfg;

			if (rec_start)
				rec_cnt <= '0;
			else if (i_sample_tick && mode_r == MODE_RECD)
				rec_cnt <= time_step(rec_cnt);

			if (play_start)
				play_cnt <= '0;
			else if (i_sample_tick && mode_r == MODE_PLAY)
				play_cnt <= time_step(play_cnt);
		end
	end

	assign o_mode        = mode_r;
	assign o_play_cfg    = cfg_r;
	assign o_record_time = rec_cnt[TW+5:TW];
	assign o_play_time   = play_cnt[TW+5:TW];

endmodule

`default_nettype wire

// ==== design/aud_pkg.sv ====
`default_nettype none

package aud_pkg;

	localparam int SAMPLE_W = 16;

	// controller modes, as shown on o_mode
	typedef enum logic [2:0] {
		MODE_STOP       = 3'd0,
		MODE_RECD       = 3'd1,
		MODE_RECD_PAUSE = 3'd2,
		MODE_PLAY       = 3'd3,
		MODE_PLAY_PAUSE = 3'd4
	} aud_mode_e;

	typedef enum logic [1:0] {
		SPD_NORMAL    = 2'd0,
		SPD_FAST      = 2'd1,
		SPD_SLOW_HOLD = 2'd2,
		SPD_SLOW_LERP = 2'd3
	} spd_kind_e;

	// factor 0 behaves as 1
	typedef struct packed {
		spd_kind_e  kind;
		logic [3:0] factor;
	} play_cfg_t;

	// recorder write request, addr is zero-extended from ADDR_W
	typedef struct packed {
		logic                wr;
		logic [19:0]         addr;
		logic [SAMPLE_W-1:0] wdata;
	} sram_req_t;

endpackage

`default_nettype wire
